// File: design/tomasulo_macros.svh
`ifndef TOMASULO_MACROS_SVH
`define TOMASULO_MACROS_SVH

// Architectural registers
`define NUM_REGS 32

// Rename tags in circulation
`define TAG_COUNT 64
`define TAG_W 6

// Data path width
`define WORD_W 32

`endif

// File: design/isa_pkg.sv
package isa_pkg;

   // Instruction fields
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;
   typedef logic [4:0] reg_addr_t;
   typedef logic [15:0] imm_t;

   // Operation code handed to the integer queue
   typedef logic [2:0] int_op_t;

   // Major opcodes, MIPS values
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   // R-type function codes
   localparam funct_t FN_ADD  = 6'h20;
   localparam funct_t FN_SUB  = 6'h22;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_SLT  = 6'h2a;
   localparam funct_t FN_MULT = 6'h18;
   localparam funct_t FN_DIV  = 6'h1a;

   // Integer queue encoding
   localparam int_op_t INT_ADD = 3'd0;
   localparam int_op_t INT_SUB = 3'd1;
   localparam int_op_t INT_AND = 3'd2;
   localparam int_op_t INT_OR  = 3'd3;
   localparam int_op_t INT_SLT = 3'd4;

endpackage

// File: design/dispatch_pkg.sv
`include "tomasulo_macros.svh"

package dispatch_pkg;

   // Rename tag of an in-flight result
   typedef logic [`TAG_W-1:0] tag_t;

   // Data word as carried on the CDB and in the register file
   typedef logic [`WORD_W-1:0] word_t;

   // One bit per architectural register
   typedef logic [`NUM_REGS-1:0] reg_onehot_t;

   // Output slot between decode and the issue queues
   typedef enum logic {
      SLOT_EMPTY,
      SLOT_FULL
   } slot_state_t;

endpackage

// File: design/regfile.sv
`timescale 1ns/1ps
`include "tomasulo_macros.svh"

module regfile (
   input  logic                     clk,
   input  logic                     arst_n,
   input  dispatch_pkg::reg_onehot_t wen_onehot,
   input  dispatch_pkg::word_t      cdb_data,
   input  isa_pkg::reg_addr_t       rs_addr,
   input  isa_pkg::reg_addr_t       rt_addr,
   output dispatch_pkg::word_t      rs_data,
   output dispatch_pkg::word_t      rt_data,
   input  isa_pkg::reg_addr_t       debug_addr,
   output dispatch_pkg::word_t      debug_data
);

   dispatch_pkg::word_t regs [`NUM_REGS];

   // CDB result lands in every register still waiting on that tag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (wen_onehot[i]) begin
               regs[i] <= cdb_data;
            end
         end
      end
   end

   // Combinational reads, r0 hard-wired to zero
   assign rs_data    = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data    = (rt_addr == '0) ? '0 : regs[rt_addr];
   // Debug view sees a CDB write one cycle later
   assign debug_data = (debug_addr == '0) ? '0 : regs[debug_addr];

endmodule

// File: design/reg_status.sv
`timescale 1ns/1ps
`include "tomasulo_macros.svh"

module reg_status (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      mark_en,
   input  isa_pkg::reg_addr_t        mark_addr,
   input  dispatch_pkg::tag_t        mark_tag,
   input  dispatch_pkg::tag_t        cdb_tag,
   input  logic                      cdb_valid,
   input  isa_pkg::reg_addr_t        rs_addr,
   input  isa_pkg::reg_addr_t        rt_addr,
   output logic                      rs_busy,
   output logic                      rt_busy,
   output dispatch_pkg::tag_t        rs_tag,
   output dispatch_pkg::tag_t        rt_tag,
   output dispatch_pkg::reg_onehot_t wen_onehot
);

   // Busy flag and producing tag per register
   dispatch_pkg::reg_onehot_t busy;
   dispatch_pkg::tag_t        tags [`NUM_REGS];

   // A busy register whose tag is on the CDB gets written this cycle
   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         wen_onehot[i] = cdb_valid && busy[i] && (tags[i] == cdb_tag);
      end
   end

   // New mark beats a completing result on the same register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (mark_en && (mark_addr == isa_pkg::reg_addr_t'(i))) begin
               busy[i] <= 1'b1;
            end else if (wen_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

   // Tag only meaningful while busy
   always_ff @(posedge clk) begin
      if (mark_en) begin
         tags[mark_addr] <= mark_tag;
      end
   end

   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];
   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];

endmodule

// File: design/tag_pool.sv
`timescale 1ns/1ps
`include "tomasulo_macros.svh"

module tag_pool (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               tag_pop,
   output dispatch_pkg::tag_t pool_tag,
   output logic               pool_empty,
   input  dispatch_pkg::tag_t cdb_tag,
   input  logic               cdb_valid
);

   dispatch_pkg::tag_t fifo [`TAG_COUNT];
   // Pointers wrap on their own, depth is a power of two
   dispatch_pkg::tag_t rd_ptr;
   dispatch_pkg::tag_t wr_ptr;
   // One extra bit to hold a full pool
   logic [`TAG_W:0]    count;

   // Completed tag goes back to the tail
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // Pool starts with every tag, in order
         for (int i = 0; i < `TAG_COUNT; i++) begin
            fifo[i] <= dispatch_pkg::tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (`TAG_W+1)'(`TAG_COUNT);
      end else begin
         if (cdb_valid) begin
            fifo[wr_ptr] <= cdb_tag;
            wr_ptr       <= wr_ptr + 1'b1;
         end
         if (tag_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Pop and push together leave the count alone
         case ({tag_pop, cdb_valid})
            2'b10:   count <= count - 1'b1;
            2'b01:   count <= count + 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head of the pool, first-word fall-through
   assign pool_tag   = fifo[rd_ptr];
   assign pool_empty = (count == '0);

endmodule

// File: design/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   input  dispatch_pkg::word_t ifq_inst,
   input  logic                ifq_empty,
   output logic                ifq_rd_en,
   input  dispatch_pkg::tag_t  cdb_tag,
   input  dispatch_pkg::word_t cdb_data,
   input  logic                cdb_valid,
   output isa_pkg::imm_t       equeue_imm,
   output dispatch_pkg::tag_t  equeue_rdtag,
   output dispatch_pkg::tag_t  equeue_rstag,
   output dispatch_pkg::tag_t  equeue_rttag,
   output dispatch_pkg::word_t equeue_rsdata,
   output dispatch_pkg::word_t equeue_rtdata,
   output logic                equeue_rsvalid,
   output logic                equeue_rtvalid,
   output logic                equeuels_opcode,
   output isa_pkg::int_op_t    equeueint_opcode,
   output logic                equeuels_en,
   output logic                equeueint_en,
   output logic                equeuemult_en,
   output logic                equeuediv_en,
   input  logic                equeuels_ready,
   input  logic                equeueint_ready,
   input  logic                equeuemult_ready,
   input  logic                equeuediv_ready,
   output logic                illegal_inst,
   output isa_pkg::reg_addr_t  rs_addr,
   output isa_pkg::reg_addr_t  rt_addr,
   input  dispatch_pkg::word_t rs_data,
   input  dispatch_pkg::word_t rt_data,
   input  logic                rs_busy,
   input  logic                rt_busy,
   input  dispatch_pkg::tag_t  rs_tag,
   input  dispatch_pkg::tag_t  rt_tag,
   output logic                mark_en,
   output isa_pkg::reg_addr_t  mark_addr,
   output dispatch_pkg::tag_t  mark_tag,
   input  dispatch_pkg::tag_t  pool_tag,
   input  logic                pool_empty,
   output logic                tag_pop
);

   // Bit positions of the one-hot target queue
   localparam int Q_LS   = 0;
   localparam int Q_INT  = 1;
   localparam int Q_MULT = 2;
   localparam int Q_DIV  = 3;

   isa_pkg::opcode_t   opcode;
   isa_pkg::funct_t    funct;
   isa_pkg::reg_addr_t rd_addr;

   logic               dec_legal;
   logic [3:0]         dec_queue;
   isa_pkg::int_op_t   dec_int_op;
   logic               dec_ls_op;
   logic               dec_alloc;
   logic               dec_use_rt;
   isa_pkg::reg_addr_t dec_dest;
   isa_pkg::imm_t      dec_imm;

   logic                rs_reg, rt_reg;
   logic                rs_fwd, rt_fwd;
   logic                op_rs_valid, op_rt_valid;
   dispatch_pkg::word_t op_rs_data, op_rt_data;
   dispatch_pkg::tag_t  op_rs_tag, op_rt_tag;

   dispatch_pkg::slot_state_t slot_state;
   logic [3:0]                slot_queue;
   logic                      slot_full, xfer, slot_free;
   logic                      needs_tag, pop, load;

   // Head instruction fields
   assign opcode  = ifq_inst[31:26];
   assign rs_addr = ifq_inst[25:21];
   assign rt_addr = ifq_inst[20:16];
   assign rd_addr = ifq_inst[15:11];
   assign funct   = ifq_inst[5:0];

   // Decode into target queue, operation and destination
   always_comb begin
      dec_legal  = 1'b1;
      dec_queue  = '0;
      dec_int_op = isa_pkg::INT_ADD;
      dec_ls_op  = 1'b0;
      dec_alloc  = 1'b0;
      dec_use_rt = 1'b1;
      dec_dest   = rd_addr;
      dec_imm    = '0;
      case (opcode)
         isa_pkg::OP_RTYPE: begin
            dec_alloc = 1'b1;
            case (funct)
               isa_pkg::FN_ADD: dec_queue[Q_INT] = 1'b1;
               isa_pkg::FN_SUB: begin
                  dec_queue[Q_INT] = 1'b1;
                  dec_int_op       = isa_pkg::INT_SUB;
               end
               isa_pkg::FN_AND: begin
                  dec_queue[Q_INT] = 1'b1;
                  dec_int_op       = isa_pkg::INT_AND;
               end
               isa_pkg::FN_OR: begin
                  dec_queue[Q_INT] = 1'b1;
                  dec_int_op       = isa_pkg::INT_OR;
               end
               isa_pkg::FN_SLT: begin
                  dec_queue[Q_INT] = 1'b1;
                  dec_int_op       = isa_pkg::INT_SLT;
               end
               isa_pkg::FN_MULT: dec_queue[Q_MULT] = 1'b1;
               isa_pkg::FN_DIV:  dec_queue[Q_DIV]  = 1'b1;
               default:          dec_legal = 1'b0;
            endcase
         end
         // lw writes rt and reads only rs
         isa_pkg::OP_LW: begin
            dec_queue[Q_LS] = 1'b1;
            dec_alloc       = 1'b1;
            dec_use_rt      = 1'b0;
            dec_dest        = rt_addr;
            dec_imm         = ifq_inst[15:0];
         end
         // sw reads both and produces no register result
         isa_pkg::OP_SW: begin
            dec_queue[Q_LS] = 1'b1;
            dec_ls_op       = 1'b1;
            dec_imm         = ifq_inst[15:0];
         end
         default: dec_legal = 1'b0;
      endcase
   end

   // Source is ready in the register file, or arriving on the CDB right now
   assign rs_reg = (rs_addr == '0) || !rs_busy;
   assign rt_reg = (rt_addr == '0) || !rt_busy || !dec_use_rt;
   assign rs_fwd = cdb_valid && (cdb_tag == rs_tag);
   assign rt_fwd = cdb_valid && (cdb_tag == rt_tag);

   assign op_rs_valid = rs_reg || rs_fwd;
   assign op_rs_data  = rs_reg ? rs_data : cdb_data;
   assign op_rs_tag   = op_rs_valid ? '0 : rs_tag;

   // Unused rt reads as a valid zero
   assign op_rt_valid = rt_reg || rt_fwd;
   assign op_rt_data  = !dec_use_rt ? '0 : (rt_reg ? rt_data : cdb_data);
   assign op_rt_tag   = op_rt_valid ? '0 : rt_tag;

   // Transfer happens when the target queue is ready
   assign slot_full        = (slot_state == dispatch_pkg::SLOT_FULL);
   assign equeuels_en      = slot_full && slot_queue[Q_LS]   && equeuels_ready;
   assign equeueint_en     = slot_full && slot_queue[Q_INT]  && equeueint_ready;
   assign equeuemult_en    = slot_full && slot_queue[Q_MULT] && equeuemult_ready;
   assign equeuediv_en     = slot_full && slot_queue[Q_DIV]  && equeuediv_ready;
   assign xfer = equeuels_en || equeueint_en || equeuemult_en || equeuediv_en;

   // Slot can take a new entry in the cycle it drains
   assign slot_free = !slot_full || xfer;
   assign needs_tag = dec_legal && dec_alloc;
   // No pops while reset is held
   assign pop       = arst_n && !ifq_empty && slot_free && (!needs_tag || !pool_empty);
   assign load      = pop && dec_legal;
   assign ifq_rd_en = pop;

   // Rename the destination, never for r0
   assign tag_pop   = pop && needs_tag;
   assign mark_en   = tag_pop && (dec_dest != '0);
   assign mark_addr = dec_dest;
   assign mark_tag  = pool_tag;

   // Slot FSM and illegal pulse
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         slot_state   <= dispatch_pkg::SLOT_EMPTY;
         illegal_inst <= 1'b0;
      end else begin
         illegal_inst <= pop && !dec_legal;
         if (load) begin
            slot_state <= dispatch_pkg::SLOT_FULL;
         end else if (xfer) begin
            slot_state <= dispatch_pkg::SLOT_EMPTY;
         end
      end
   end

   // Slot payload, snooping the CDB while it waits
   always_ff @(posedge clk) begin
      if (load) begin
         slot_queue       <= dec_queue;
         equeue_imm       <= dec_imm;
         equeue_rdtag     <= needs_tag ? pool_tag : '0;
         equeue_rstag     <= op_rs_tag;
         equeue_rttag     <= op_rt_tag;
         equeue_rsdata    <= op_rs_data;
         equeue_rtdata    <= op_rt_data;
         equeue_rsvalid   <= op_rs_valid;
         equeue_rtvalid   <= op_rt_valid;
         equeuels_opcode  <= dec_ls_op;
         equeueint_opcode <= dec_int_op;
      end else if (slot_full) begin
         if (!equeue_rsvalid && cdb_valid && (cdb_tag == equeue_rstag)) begin
            equeue_rsvalid <= 1'b1;
            equeue_rsdata  <= cdb_data;
         end
         if (!equeue_rtvalid && cdb_valid && (cdb_tag == equeue_rttag)) begin
            equeue_rtvalid <= 1'b1;
            equeue_rtdata  <= cdb_data;
         end
      end
   end

endmodule

// File: design/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
   input  logic                clk,
   input  logic                arst_n,
   input  dispatch_pkg::word_t ifq_inst,
   input  logic                ifq_empty,
   output logic                ifq_rd_en,
   input  dispatch_pkg::tag_t  cdb_tag,
   input  dispatch_pkg::word_t cdb_data,
   input  logic                cdb_valid,
   output isa_pkg::imm_t       equeue_imm,
   output dispatch_pkg::tag_t  equeue_rdtag,
   output dispatch_pkg::tag_t  equeue_rstag,
   output dispatch_pkg::tag_t  equeue_rttag,
   output dispatch_pkg::word_t equeue_rsdata,
   output dispatch_pkg::word_t equeue_rtdata,
   output logic                equeue_rsvalid,
   output logic                equeue_rtvalid,
   output logic                equeuels_opcode,
   output isa_pkg::int_op_t    equeueint_opcode,
   output logic                equeuels_en,
   output logic                equeueint_en,
   output logic                equeuemult_en,
   output logic                equeuediv_en,
   input  logic                equeuels_ready,
   input  logic                equeueint_ready,
   input  logic                equeuemult_ready,
   input  logic                equeuediv_ready,
   output logic                illegal_inst,
   input  isa_pkg::reg_addr_t  debug_addr,
   output dispatch_pkg::word_t debug_data
);

   // Operand lookup, shared addresses into register file and status table
   isa_pkg::reg_addr_t        rs_addr, rt_addr;
   dispatch_pkg::word_t       rs_data, rt_data;
   logic                      rs_busy, rt_busy;
   dispatch_pkg::tag_t        rs_tag, rt_tag;

   // Destination rename
   logic                      mark_en;
   isa_pkg::reg_addr_t        mark_addr;
   dispatch_pkg::tag_t        mark_tag;
   dispatch_pkg::tag_t        pool_tag;
   logic                      pool_empty;
   logic                      tag_pop;

   // CDB write select from status table into register file
   dispatch_pkg::reg_onehot_t wen_onehot;

   // Port names match the nets above
   dispatch_ctrl u_dispatch_ctrl (.*);

   regfile u_regfile (.*);

   reg_status u_reg_status (.*);

   tag_pool u_tag_pool (.*);

endmodule

// File: tb/dispatch_asserts.sv
`timescale 1ns/1ps

module dispatch_asserts (
   input logic clk,
   input logic arst_n,
   input logic ifq_empty,
   input logic ifq_rd_en,
   input logic equeuels_en,
   input logic equeueint_en,
   input logic equeuemult_en,
   input logic equeuediv_en,
   input logic equeuels_ready,
   input logic equeueint_ready,
   input logic equeuemult_ready,
   input logic equeuediv_ready,
   input logic illegal_inst
);

   // Slot goes to a single queue
   a_one_enable: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({equeuels_en, equeueint_en, equeuemult_en, equeuediv_en}))
      else $error("more than one issue queue enable high");

   // Enable implies the queue can take it
   a_enable_ready: assert property (@(posedge clk) disable iff (!arst_n)
      !((equeuels_en && !equeuels_ready) || (equeueint_en && !equeueint_ready) ||
        (equeuemult_en && !equeuemult_ready) || (equeuediv_en && !equeuediv_ready)))
      else $error("issue queue enable without ready");

   // No pop from an empty IFQ
   a_pop_nonempty: assert property (@(posedge clk) disable iff (!arst_n)
      ifq_rd_en |-> !ifq_empty)
      else $error("ifq_rd_en high while ifq_empty");

   a_illegal_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      illegal_inst |=> !illegal_inst)
      else $error("illegal_inst high for more than one cycle");

endmodule

bind dispatch_unit dispatch_asserts u_dispatch_asserts (
   .clk              (clk),
   .arst_n           (arst_n),
   .ifq_empty        (ifq_empty),
   .ifq_rd_en        (ifq_rd_en),
   .equeuels_en      (equeuels_en),
   .equeueint_en     (equeueint_en),
   .equeuemult_en    (equeuemult_en),
   .equeuediv_en     (equeuediv_en),
   .equeuels_ready   (equeuels_ready),
   .equeueint_ready  (equeueint_ready),
   .equeuemult_ready (equeuemult_ready),
   .equeuediv_ready  (equeuediv_ready),
   .illegal_inst     (illegal_inst)
);

// File: tb/tb_dispatch_tests.svh
// Two independent adds straight after reset
task automatic test_basic_add();
   xfer_t x;
   start_test("basic_add");
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd0, 5'd2, 5'd1));
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd0, 5'd4, 5'd3));
   release_ifq();
   wait_xfers(2);
   check_entry(0, Q_INT, 0);
   check_entry(1, Q_INT, 1);
   x = get_xfer(0);
   check_eq("int op", 0, int'(x.intop));
   check_eq("rsvalid", 1, int'(x.rsvalid));
   check_eq("rsdata", 0, int'(x.rsdata));
   check_eq("rtvalid", 1, int'(x.rtvalid));
   check_eq("rtdata", 0, int'(x.rtdata));
   finish_test();
endtask

// Reader waits on a tag, then picks the value up from the register file
task automatic test_dependency();
   xfer_t               x;
   dispatch_pkg::word_t word;
   start_test("dependency");
   word = $random(seed);
   // r1 gets tag 0, r5 reads it
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd0, 5'd0, 5'd1));
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd1, 5'd0, 5'd5));
   release_ifq();
   wait_xfers(2);
   check_entry(1, Q_INT, 1);
   x = get_xfer(1);
   check_eq("rsvalid of pending reader", 0, int'(x.rsvalid));
   check_eq("rstag of pending reader", 0, int'(x.rstag));
   debug_addr = 5'd1;
   broadcast(6'd0, word);
   check_eq("debug_data of r1", int'(word), int'(debug_data));
   // Tag 0 went back to the tail, so 2 is next
   // r5 still waits on tag 1 and shows up through rt
   push_inst(enc_rtype(isa_pkg::FN_SUB, 5'd1, 5'd5, 5'd6));
   release_ifq();
   wait_xfers(3);
   check_entry(2, Q_INT, 2);
   x = get_xfer(2);
   check_eq("rsvalid of later reader", 1, int'(x.rsvalid));
   check_eq("rsdata of later reader", int'(word), int'(x.rsdata));
   check_eq("rtvalid of later reader", 0, int'(x.rtvalid));
   check_eq("rttag of later reader", 1, int'(x.rttag));
   finish_test();
endtask

// Held slot snoops the CDB while the integer queue is full
task automatic test_backpressure();
   xfer_t               x;
   dispatch_pkg::word_t word;
   start_test("backpressure");
   word            = $random(seed);
   equeueint_ready = 1'b0;
   push_inst(enc_itype(isa_pkg::OP_LW, 5'd0, 5'd1, 16'h0010));
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd1, 5'd0, 5'd2));
   release_ifq();
   wait_xfers(1);
   repeat (4) tick();
   check_eq("transfers while held", 1, xfer_log.size());
   broadcast(6'd0, word);
   repeat (2) tick();
   equeueint_ready = 1'b1;
   wait_xfers(2);
   repeat (5) tick();
   // One transfer each, nothing repeated
   check_eq("transfers after release", 2, xfer_log.size());
   check_entry(0, Q_LS, 0);
   check_entry(1, Q_INT, 1);
   x = get_xfer(1);
   check_eq("rsvalid after snoop", 1, int'(x.rsvalid));
   check_eq("rsdata after snoop", int'(word), int'(x.rsdata));
   check_eq("rtvalid after snoop", 1, int'(x.rtvalid));
   finish_test();
endtask

// Every instruction class lands in its own queue
task automatic test_routing();
   xfer_t         x;
   isa_pkg::imm_t imm_a;
   isa_pkg::imm_t imm_b;
   int            exp_q [8];
   int            exp_tag [8];
   start_test("routing");
   imm_a = 16'($random(seed));
   imm_b = 16'($random(seed));
   push_inst(enc_itype(isa_pkg::OP_LW, 5'd2, 5'd1, imm_a));
   push_inst(enc_itype(isa_pkg::OP_SW, 5'd4, 5'd3, imm_b));
   push_inst(enc_rtype(isa_pkg::FN_MULT, 5'd6, 5'd7, 5'd5));
   push_inst(enc_rtype(isa_pkg::FN_DIV, 5'd9, 5'd10, 5'd8));
   push_inst(enc_rtype(isa_pkg::FN_SUB, 5'd0, 5'd0, 5'd11));
   push_inst(enc_rtype(isa_pkg::FN_AND, 5'd0, 5'd0, 5'd12));
   push_inst(enc_rtype(isa_pkg::FN_OR, 5'd0, 5'd0, 5'd13));
   push_inst(enc_rtype(isa_pkg::FN_SLT, 5'd0, 5'd0, 5'd14));
   release_ifq();
   // sw takes no tag, so mult follows lw directly
   exp_q   = '{Q_LS, Q_LS, Q_MULT, Q_DIV, Q_INT, Q_INT, Q_INT, Q_INT};
   exp_tag = '{0, 0, 1, 2, 3, 4, 5, 6};
   wait_xfers(8);
   for (int i = 0; i < 8; i++) begin
      check_entry(i, exp_q[i], exp_tag[i]);
   end
   x = get_xfer(0);
   check_eq("lw opcode", 0, int'(x.lsop));
   check_eq("lw imm", int'(imm_a), int'(x.imm));
   x = get_xfer(1);
   check_eq("sw opcode", 1, int'(x.lsop));
   check_eq("sw imm", int'(imm_b), int'(x.imm));
   // sub, and, or, slt in order
   for (int i = 4; i < 8; i++) begin
      x = get_xfer(i);
      check_eq($sformatf("int op of transfer %0d", i), i - 3, int'(x.intop));
   end
   finish_test();
endtask

// Pool runs dry, one returned tag lets the stalled add through
task automatic test_tag_exhaustion();
   dispatch_pkg::word_t word;
   start_test("tag_exhaustion");
   word = $random(seed);
   for (int i = 0; i < `TAG_COUNT + 1; i++) begin
      push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd0, 5'd0, 5'd1));
   end
   release_ifq();
   wait_xfers(`TAG_COUNT);
   for (int i = 0; i < `TAG_COUNT; i++) begin
      check_entry(i, Q_INT, i);
   end
   repeat (10) tick();
   check_eq("pops with empty pool", `TAG_COUNT, pop_count);
   check_eq("transfers with empty pool", `TAG_COUNT, xfer_log.size());
   broadcast(6'd5, word);
   wait_xfers(`TAG_COUNT + 1);
   check_entry(`TAG_COUNT, Q_INT, 5);
   finish_test();
endtask

// Unknown opcode is dropped and flagged
task automatic test_illegal();
   start_test("illegal");
   push_inst(32'hfc00_0000);
   push_inst(enc_rtype(isa_pkg::FN_ADD, 5'd0, 5'd0, 5'd1));
   release_ifq();
   wait_xfers(1);
   repeat (3) tick();
   check_eq("illegal pulses", 1, illegal_count);
   check_eq("transfers", 1, xfer_log.size());
   check_entry(0, Q_INT, 0);
   finish_test();
endtask

// File: tb/tb_dispatch.sv
`timescale 1ns/1ps
`include "tomasulo_macros.svh"

module tb_dispatch;

   localparam int CLK_PERIOD = 4;
   localparam int NUM_TESTS  = 6;
   // 200 cycles per test, plus room for draining the whole tag pool
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + `TAG_COUNT;

   // Queue ids as recorded in the transfer log
   localparam int Q_LS   = 0;
   localparam int Q_INT  = 1;
   localparam int Q_MULT = 2;
   localparam int Q_DIV  = 3;

   // One transfer into an issue queue
   typedef struct packed {
      logic [1:0]          queue;
      dispatch_pkg::tag_t  rdtag;
      dispatch_pkg::tag_t  rstag;
      logic                rsvalid;
      dispatch_pkg::word_t rsdata;
      dispatch_pkg::tag_t  rttag;
      logic                rtvalid;
      dispatch_pkg::word_t rtdata;
      isa_pkg::imm_t       imm;
      logic                lsop;
      isa_pkg::int_op_t    intop;
   } xfer_t;

   logic                clk;
   logic                arst_n;
   dispatch_pkg::word_t ifq_inst;
   logic                ifq_empty;
   logic                ifq_rd_en;
   dispatch_pkg::tag_t  cdb_tag;
   dispatch_pkg::word_t cdb_data;
   logic                cdb_valid;
   isa_pkg::imm_t       equeue_imm;
   dispatch_pkg::tag_t  equeue_rdtag;
   dispatch_pkg::tag_t  equeue_rstag;
   dispatch_pkg::tag_t  equeue_rttag;
   dispatch_pkg::word_t equeue_rsdata;
   dispatch_pkg::word_t equeue_rtdata;
   logic                equeue_rsvalid;
   logic                equeue_rtvalid;
   logic                equeuels_opcode;
   isa_pkg::int_op_t    equeueint_opcode;
   logic                equeuels_en;
   logic                equeueint_en;
   logic                equeuemult_en;
   logic                equeuediv_en;
   logic                equeuels_ready;
   logic                equeueint_ready;
   logic                equeuemult_ready;
   logic                equeuediv_ready;
   logic                illegal_inst;
   isa_pkg::reg_addr_t  debug_addr;
   dispatch_pkg::word_t debug_data;

   // IFQ model storage, indices only grow over the run
   dispatch_pkg::word_t ifq_mem [256];
   dispatch_pkg::word_t stage [$];
   int                  head;
   int                  tail;
   logic                pop_seen;

   xfer_t xfer_log [$];
   int    illegal_count;
   int    pop_count;
   int    pushed_count;

   int    seed;
   string test_name;
   int    errors;
   int    test_errors_at_start;
   int    pass_count;
   int    fail_count;

   dispatch_unit u_dispatch_unit (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Mid-cycle sampling, all outputs settled
   always @(negedge clk) begin
      xfer_t x;
      pop_seen = ifq_rd_en;
      if (ifq_rd_en) begin
         pop_count++;
      end
      if (illegal_inst) begin
         illegal_count++;
      end
      if (equeuels_en || equeueint_en || equeuemult_en || equeuediv_en) begin
         x.queue   = equeuels_en ? 2'd0 : equeueint_en ? 2'd1 : equeuemult_en ? 2'd2 : 2'd3;
         x.rdtag   = equeue_rdtag;
         x.rstag   = equeue_rstag;
         x.rsvalid = equeue_rsvalid;
         x.rsdata  = equeue_rsdata;
         x.rttag   = equeue_rttag;
         x.rtvalid = equeue_rtvalid;
         x.rtdata  = equeue_rtdata;
         x.imm     = equeue_imm;
         x.lsop    = equeuels_opcode;
         x.intop   = equeueint_opcode;
         xfer_log.push_back(x);
      end
   end

   // First-word fall-through IFQ, head moves after a sampled pop
   always begin
      @(posedge clk);
      #1;
      if (pop_seen) begin
         head++;
      end
      ifq_empty = (head == tail);
      ifq_inst  = (head < tail) ? ifq_mem[head] : '0;
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      arst_n           = 1'b0;
      cdb_valid        = 1'b0;
      cdb_tag          = '0;
      cdb_data         = '0;
      debug_addr       = '0;
      equeuels_ready   = 1'b1;
      equeueint_ready  = 1'b1;
      equeuemult_ready = 1'b1;
      equeuediv_ready  = 1'b1;
      tick();
      tick();
      xfer_log.delete();
      illegal_count = 0;
      pop_count     = 0;
      pushed_count  = 0;
      arst_n        = 1'b1;
   endtask

   function automatic dispatch_pkg::word_t enc_rtype(input isa_pkg::funct_t fn,
                                                     input isa_pkg::reg_addr_t rs,
                                                     input isa_pkg::reg_addr_t rt,
                                                     input isa_pkg::reg_addr_t rd);
      return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic dispatch_pkg::word_t enc_itype(input isa_pkg::opcode_t op,
                                                     input isa_pkg::reg_addr_t rs,
                                                     input isa_pkg::reg_addr_t rt,
                                                     input isa_pkg::imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic push_inst(input dispatch_pkg::word_t inst);
      stage.push_back(inst);
      pushed_count++;
   endtask

   // Staged words enter the IFQ away from the driver's edge
   task automatic release_ifq();
      @(negedge clk);
      foreach (stage[i]) begin
         ifq_mem[tail] = stage[i];
         tail++;
      end
      stage.delete();
      tick();
   endtask

   // One cycle of CDB traffic
   task automatic broadcast(input dispatch_pkg::tag_t tag, input dispatch_pkg::word_t data);
      cdb_valid = 1'b1;
      cdb_tag   = tag;
      cdb_data  = data;
      tick();
      cdb_valid = 1'b0;
   endtask

   task automatic wait_xfers(input int n);
      int waited;
      waited = 0;
      while (xfer_log.size() < n && waited < 150) begin
         tick();
         waited++;
      end
      if (xfer_log.size() < n) begin
         $display("[%s] timed out waiting for %0d queue transfers, saw %0d",
                  test_name, n, xfer_log.size());
         errors++;
      end
   endtask

   function automatic xfer_t get_xfer(input int idx);
      if (idx < xfer_log.size()) begin
         return xfer_log[idx];
      end
      return '0;
   endfunction

   task automatic check_eq(input string field, input int expected, input int actual);
      if (expected != actual) begin
         $display("ERR [%s] %s: expected %0h, actual %0h", test_name, field, expected, actual);
         errors++;
      end
   endtask

   task automatic check_entry(input int idx, input int exp_queue, input int exp_rdtag);
      xfer_t x;
      if (idx >= xfer_log.size()) begin
         $display("[%s] transfer %0d never reached an issue queue", test_name, idx);
         errors++;
      end else begin
         x = xfer_log[idx];
         check_eq($sformatf("queue of transfer %0d", idx), exp_queue, int'(x.queue));
         check_eq($sformatf("rdtag of transfer %0d", idx), exp_rdtag, int'(x.rdtag));
      end
   endtask

   task automatic start_test(input string name);
      test_name            = name;
      test_errors_at_start = errors;
      apply_reset();
   endtask

   task automatic finish_test();
      if (pop_count != pushed_count) begin
         $display("[%s] only %0d of %0d instructions were popped from the IFQ",
                  test_name, pop_count, pushed_count);
         errors++;
      end
      if (errors == test_errors_at_start) begin
         pass_count++;
         $display("%s: pass", test_name);
      end else begin
         fail_count++;
         $display("%s: fail with %0d errors", test_name, errors - test_errors_at_start);
      end
   endtask

   `include "tb_dispatch_tests.svh"

   initial begin
      arst_n           = 1'b0;
      ifq_inst         = '0;
      ifq_empty        = 1'b1;
      cdb_tag          = '0;
      cdb_data         = '0;
      cdb_valid        = 1'b0;
      equeuels_ready   = 1'b1;
      equeueint_ready  = 1'b1;
      equeuemult_ready = 1'b1;
      equeuediv_ready  = 1'b1;
      debug_addr       = '0;
      head             = 0;
      tail             = 0;
      pop_seen         = 1'b0;
      seed             = 45313;
      errors           = 0;
      pass_count       = 0;
      fail_count       = 0;

      test_basic_add();
      test_dependency();
      test_backpressure();
      test_routing();
      test_tag_exhaustion();
      test_illegal();

      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Hang guard
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+design
+incdir+tb
design/isa_pkg.sv
design/dispatch_pkg.sv
design/regfile.sv
design/reg_status.sv
design/tag_pool.sv
design/dispatch_ctrl.sv
design/dispatch_unit.sv
tb/dispatch_asserts.sv
tb/tb_dispatch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f filelist.f \
      --top-module tb_dispatch -o tb_dispatch_sim; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_dispatch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi

exit 0
